// File: test/dac_golden.txt
# mode(0 dsp, 1 host, 2 dsp left and host right at once) tint left right
# then expected high ticks for ldac[0] ldac[1] rdac[0] rdac[1]
0 1 8000 8000 0 0 0 0
0 1 0004 01fc 2 65 128 65
1 1 8200 fe00 0 2 0 64
1 1 7e00 0028 0 128 11 65
2 1 1234 abcd 14 74 116 22
0 0 0100 0100 14 74 116 22
0 1 0100 0100 65 65 65 65
1 1 ffff 0000 128 64 0 65
2 1 0003 0002 0 65 0 65

// File: src.f
+incdir+src
src/dac_bus_pkg.sv
src/dac_pwm_pkg.sv
src/dac_bus_if.sv
src/bus_arbiter.sv
src/dac_regs.sv
src/pwm_engine.sv
src/audio_dac_top.sv
test/dac_properties.sv
test/dac_checker.sv
test/tb_audio_dac.sv

// File: Bender.yml
package:
  name: audio_dac

sources:
  - include_dirs:
      - src
    files:
      - src/dac_bus_pkg.sv
      - src/dac_pwm_pkg.sv
      - src/dac_bus_if.sv
      - src/bus_arbiter.sv
      - src/dac_regs.sv
      - src/pwm_engine.sv
      - src/audio_dac_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/dac_properties.sv
      - test/dac_checker.sv
      - test/tb_audio_dac.sv

// File: test/tb_audio_dac.sv
/* Audio DAC testbench */

`timescale 1ns/10ps
`default_nettype none

`include "dac_defs.svh"

module tb_audio_dac;
	import dac_bus_pkg::*;

	localparam int MAX_TESTS = 64;
	localparam int RUN_TICKS = 140;

	logic sys_clk;
	logic resetl;
	logic dac_tick;
	logic tint;
	logic ts;
	logic dsp_req;
	dac_sel_e dsp_sel;
	logic [`DAC_SAMPLE_W-1:0] dsp_data;
	logic dsp_ack;
	logic host_req;
	dac_sel_e host_sel;
	logic [`DAC_SAMPLE_W-1:0] host_data;
	logic host_ack;
	logic [1:0] ldac;
	logic [1:0] rdac;

	logic check;
	logic [7:0] exp_l0;
	logic [7:0] exp_l1;
	logic [7:0] exp_r0;
	logic [7:0] exp_r1;
	int errors;

	// Golden test table
	int n_tests;
	int t_mode [MAX_TESTS];
	int t_tint [MAX_TESTS];
	logic [15:0] t_left [MAX_TESTS];
	logic [15:0] t_right [MAX_TESTS];
	int t_exp [MAX_TESTS][4];

	logic [16:0] lfsr;
	int cycles;
	int limit;

	audio_dac_top DUT (
		.sys_clk   (sys_clk),
		.resetl    (resetl),
		.dac_tick  (dac_tick),
		.tint      (tint),
		.ts        (ts),
		.dsp_req   (dsp_req),
		.dsp_sel   (dsp_sel),
		.dsp_data  (dsp_data),
		.dsp_ack   (dsp_ack),
		.host_req  (host_req),
		.host_sel  (host_sel),
		.host_data (host_data),
		.host_ack  (host_ack),
		.ldac      (ldac),
		.rdac      (rdac)
	);

	dac_checker u_checker (
		.sys_clk  (sys_clk),
		.resetl   (resetl),
		.dac_tick (dac_tick),
		.ts       (ts),
		.ldac     (ldac),
		.rdac     (rdac),
		.dsp_ack  (dsp_ack),
		.host_ack (host_ack),
		.check    (check),
		.exp_l0   (exp_l0),
		.exp_l1   (exp_l1),
		.exp_r0   (exp_r0),
		.exp_r1   (exp_r1),
		.errors   (errors)
	);

	// 17-bit Fibonacci LFSR, taps 17 and 14
	function automatic logic [16:0] lfsr_next(input logic [16:0] s);
		return {s[15:0], s[16] ^ s[13]};
	endfunction

	// Spacing to the next tick, 1 to 3 cycles from two LFSR bits
	function automatic int next_spacing();
		int r;
		r = 0;
		repeat (2) begin
			lfsr = lfsr_next(lfsr);
			r = (r << 1) | lfsr[0];
		end
		return (r % 3) + 1;
	endfunction

	initial begin
		sys_clk = 1'b0;
		forever #5 sys_clk = ~sys_clk;
	end

	// Tick strobe generator
	initial begin
		int wait_cnt;
		wait_cnt = 0;
		dac_tick = 1'b0;
		@(posedge resetl);
		forever begin
			@(posedge sys_clk);
			#1;
			if (wait_cnt == 0) begin
				dac_tick = 1'b1;
				wait_cnt = next_spacing() - 1;
			end else begin
				dac_tick = 1'b0;
				wait_cnt--;
			end
		end
	end

	// Run limit
	always @(posedge sys_clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("Run timed out after %0d cycles", cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	// Ends 1 ns after the edge that saw a tick
	task automatic wait_tick();
		@(posedge sys_clk);
		while (!dac_tick) begin
			@(posedge sys_clk);
		end
		#1;
	endtask

	task automatic run_ticks(input int n);
		repeat (n) wait_tick();
	endtask

	task automatic dsp_write(input dac_sel_e sel, input logic [15:0] data);
		dsp_sel = sel;
		dsp_data = data;
		dsp_req = 1'b1;
		@(posedge sys_clk);
		while (!dsp_ack) begin
			@(posedge sys_clk);
		end
		#1 dsp_req = 1'b0;
		@(posedge sys_clk);
		#1;
	endtask

	task automatic host_write(input dac_sel_e sel, input logic [15:0] data);
		host_sel = sel;
		host_data = data;
		host_req = 1'b1;
		@(posedge sys_clk);
		while (!host_ack) begin
			@(posedge sys_clk);
		end
		#1 host_req = 1'b0;
		@(posedge sys_clk);
		#1;
	endtask

	task automatic pulse_tint();
		tint = 1'b1;
		wait_tick();
		tint = 1'b0;
	endtask

	task automatic pulse_ts();
		ts = 1'b1;
		wait_tick();
		ts = 1'b0;
	endtask

	task automatic compare_counts(input int e0, input int e1, input int e2, input int e3);
		exp_l0 = e0[7:0];
		exp_l1 = e1[7:0];
		exp_r0 = e2[7:0];
		exp_r1 = e3[7:0];
		check = 1'b1;
		@(posedge sys_clk);
		#1 check = 1'b0;
	endtask

	// Skips comment lines starting with #
	task automatic load_golden(output bit ok);
		int fd;
		int n;
		string line;
		ok = 1'b0;
		n_tests = 0;
		fd = $fopen("test/dac_golden.txt", "r");
		if (fd == 0) begin
			return;
		end
		while (!$feof(fd) && n_tests < MAX_TESTS) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 1 && line[0] != "#") begin
				n = $sscanf(line, "%d %d %h %h %d %d %d %d",
					t_mode[n_tests], t_tint[n_tests], t_left[n_tests],
					t_right[n_tests], t_exp[n_tests][0], t_exp[n_tests][1],
					t_exp[n_tests][2], t_exp[n_tests][3]);
				if (n == 8) begin
					n_tests++;
				end
			end
		end
		$fclose(fd);
		ok = (n_tests > 0);
	endtask

	initial begin
		bit ok;
		lfsr = 17'd69124;
		cycles = 0;
		limit = 0;
		resetl = 1'b0;
		tint = 1'b0;
		ts = 1'b0;
		check = 1'b0;
		dsp_req = 1'b0;
		dsp_sel = SEL_LEFT;
		dsp_data = '0;
		host_req = 1'b0;
		host_sel = SEL_LEFT;
		host_data = '0;
		exp_l0 = '0;
		exp_l1 = '0;
		exp_r0 = '0;
		exp_r1 = '0;

		load_golden(ok);
		if (!ok) begin
			$display("Could not read any test from test/dac_golden.txt");
			$display("Testbench failed");
			$finish;
		end
		// One extra slot for the idle period after reset
		limit = (n_tests + 1) * (150 * 3 + 40);

		repeat (4) @(posedge sys_clk);
		#1 resetl = 1'b1;

		// No ts yet
		// The counter leaves reset at 0 and runs for a single tick
		// Cleared latches give both high halves code 64 through the inverted sign
		// So only ldac[1] and rdac[1] pulse, once each, and then all stay low
		run_ticks(RUN_TICKS);
		compare_counts(0, 1, 0, 1);

		for (int i = 0; i < n_tests; i++) begin
			case (t_mode[i])
				0: begin
					dsp_write(SEL_LEFT, t_left[i]);
					dsp_write(SEL_RIGHT, t_right[i]);
				end
				1: begin
					host_write(SEL_LEFT, t_left[i]);
					host_write(SEL_RIGHT, t_right[i]);
				end
				default: begin
					// Both request at once, DSP gets the bus first
					fork
						dsp_write(SEL_LEFT, t_left[i]);
						host_write(SEL_RIGHT, t_right[i]);
					join
				end
			endcase
			if (t_tint[i] != 0) begin
				pulse_tint();
			end
			pulse_ts();
			run_ticks(RUN_TICKS);
			compare_counts(t_exp[i][0], t_exp[i][1], t_exp[i][2], t_exp[i][3]);
		end

		repeat (4) @(posedge sys_clk);
		$display("Tests run: %0d, errors: %0d", n_tests + 1, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: test/dac_checker.sv
/* PWM pulse count checker */

`timescale 1ns/10ps
`default_nettype none

module dac_checker (
	input wire sys_clk,
	input wire resetl,
	input wire dac_tick,
	input wire ts,
	input wire [1:0] ldac,
	input wire [1:0] rdac,
	input wire dsp_ack,
	input wire host_ack,
	// Compare strobe and expected counts from the golden file
	input wire check,
	input wire [7:0] exp_l0,
	input wire [7:0] exp_l1,
	input wire [7:0] exp_r0,
	input wire [7:0] exp_r1,
	output int errors
);

	int cnt_l0;
	int cnt_l1;
	int cnt_r0;
	int cnt_r1;
	logic was_reset;

	task automatic compare(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("Error at %0t: %s high for %0d ticks, expected %0d",
				$time, name, got, exp);
			errors++;
		end
	endtask

	initial begin
		errors = 0;
	end

	always @(posedge sys_clk) begin
		was_reset <= !resetl;
		if (!resetl) begin
			cnt_l0 <= 0;
			cnt_l1 <= 0;
			cnt_r0 <= 0;
			cnt_r1 <= 0;
		end else begin
			// First cycle out of reset, everything must be quiet
			if (was_reset && (ldac != 2'b00 || rdac != 2'b00 || dsp_ack || host_ack)) begin
				$display("Error at %0t: outputs not zero after reset", $time);
				errors++;
			end
			// Window restarts on each ts tick
			if (dac_tick && ts) begin
				cnt_l0 <= 0;
				cnt_l1 <= 0;
				cnt_r0 <= 0;
				cnt_r1 <= 0;
			end else if (dac_tick) begin
				cnt_l0 <= cnt_l0 + ldac[0];
				cnt_l1 <= cnt_l1 + ldac[1];
				cnt_r0 <= cnt_r0 + rdac[0];
				cnt_r1 <= cnt_r1 + rdac[1];
			end
			if (check) begin
				compare("ldac[0]", cnt_l0, exp_l0);
				compare("ldac[1]", cnt_l1, exp_l1);
				compare("rdac[0]", cnt_r0, exp_r0);
				compare("rdac[1]", cnt_r1, exp_r1);
			end
		end
	end

endmodule

`default_nettype wire

// File: test/dac_properties.sv
/* Arbiter handshake assertions */

`timescale 1ns/10ps
`default_nettype none

`include "dac_defs.svh"

module dac_properties (
	input wire sys_clk,
	input wire resetl,
	input wire dsp_req,
	input wire dac_bus_pkg::dac_sel_e dsp_sel,
	input wire [`DAC_SAMPLE_W-1:0] dsp_data,
	input wire dsp_ack,
	input wire host_req,
	input wire dac_bus_pkg::dac_sel_e host_sel,
	input wire [`DAC_SAMPLE_W-1:0] host_data,
	input wire host_ack,
	input wire dac_bus_pkg::arb_state_e state
);
	import dac_bus_pkg::*;

	// An ack is only given to a writer that is requesting
	assert property (@(posedge sys_clk) disable iff (!resetl) dsp_ack |-> dsp_req)
		else $error("dsp_ack without dsp_req");
	assert property (@(posedge sys_clk) disable iff (!resetl) host_ack |-> host_req)
		else $error("host_ack without host_req");

	// Writers hold request, select and data until their ack
	assert property (@(posedge sys_clk) disable iff (!resetl)
		dsp_req && !dsp_ack |=> dsp_req && $stable(dsp_sel) && $stable(dsp_data))
		else $error("DSP request changed before ack");
	assert property (@(posedge sys_clk) disable iff (!resetl)
		host_req && !host_ack |=> host_req && $stable(host_sel) && $stable(host_data))
		else $error("host request changed before ack");

	// A grant only stands while its writer still requests
	assert property (@(posedge sys_clk) disable iff (!resetl)
		state == ARB_DSP |-> dsp_req)
		else $error("DSP granted without a request");
	assert property (@(posedge sys_clk) disable iff (!resetl)
		state == ARB_HOST |-> host_req)
		else $error("host granted without a request");

	// One owner at a time
	// Each ack is followed by an idle cycle before the next grant
	assert property (@(posedge sys_clk) disable iff (!resetl)
		(dsp_ack || host_ack) |=> !(dsp_ack || host_ack))
		else $error("acks on two cycles in a row");

endmodule

bind bus_arbiter dac_properties u_props (
	.sys_clk   (sys_clk),
	.resetl    (resetl),
	.dsp_req   (dsp_req),
	.dsp_sel   (dsp_sel),
	.dsp_data  (dsp_data),
	.dsp_ack   (dsp_ack),
	.host_req  (host_req),
	.host_sel  (host_sel),
	.host_data (host_data),
	.host_ack  (host_ack),
	.state     (state)
);

`default_nettype wire

// File: src/audio_dac_top.sv
/* Stereo PWM audio DAC */

`timescale 1ns/10ps
`default_nettype none

`include "dac_defs.svh"

module audio_dac_top (
	input wire sys_clk,
	input wire resetl,
	input wire dac_tick,
	input wire tint,
	input wire ts,
	// DSP writer
	input wire dsp_req,
	input wire dac_bus_pkg::dac_sel_e dsp_sel,
	input wire [`DAC_SAMPLE_W-1:0] dsp_data,
	output logic dsp_ack,
	// Host writer
	input wire host_req,
	input wire dac_bus_pkg::dac_sel_e host_sel,
	input wire [`DAC_SAMPLE_W-1:0] host_data,
	output logic host_ack,
	// Pulse outputs, bit 1 is the high half
	output logic [1:0] ldac,
	output logic [1:0] rdac
);

	// Second-stage samples into the engine
	logic [`DAC_SAMPLE_W-1:`DAC_CODE_LSB] dl2;
	logic [`DAC_SAMPLE_W-1:`DAC_CODE_LSB] dr2;

	// Arbitrated write bus
	dac_bus_if bus ();

	bus_arbiter u_arbiter (
		.sys_clk   (sys_clk),
		.resetl    (resetl),
		.dsp_req   (dsp_req),
		.dsp_sel   (dsp_sel),
		.dsp_data  (dsp_data),
		.dsp_ack   (dsp_ack),
		.host_req  (host_req),
		.host_sel  (host_sel),
		.host_data (host_data),
		.host_ack  (host_ack),
		.bus       (bus.master)
	);

	dac_regs u_regs (
		.sys_clk  (sys_clk),
		.resetl   (resetl),
		.dac_tick (dac_tick),
		.tint     (tint),
		.bus      (bus.target),
		.dl2      (dl2),
		.dr2      (dr2)
	);

	pwm_engine u_pwm (
		.sys_clk  (sys_clk),
		.resetl   (resetl),
		.dac_tick (dac_tick),
		.ts       (ts),
		.dl2      (dl2),
		.dr2      (dr2),
		.ldac     (ldac),
		.rdac     (rdac)
	);

endmodule

`default_nettype wire

// File: src/pwm_engine.sv
/* Shared-counter PWM engine */

`timescale 1ns/10ps
`default_nettype none

`include "dac_defs.svh"

module pwm_engine (
	input wire sys_clk,
	input wire resetl,
	input wire dac_tick,
	input wire ts,
	input wire [`DAC_SAMPLE_W-1:`DAC_CODE_LSB] dl2,
	input wire [`DAC_SAMPLE_W-1:`DAC_CODE_LSB] dr2,
	output logic [1:0] ldac,
	output logic [1:0] rdac
);
	import dac_pwm_pkg::*;

	logic [`DAC_CNT_W-1:0] cnt;
	pwm_phase_e phase;

	// Pulse codes per half
	logic [`DAC_HALF_W-1:0] code_l0;
	logic [`DAC_HALF_W-1:0] code_l1;
	logic [`DAC_HALF_W-1:0] code_r0;
	logic [`DAC_HALF_W-1:0] code_r1;

	// One comparator
	function automatic logic pulse_on(
		input pwm_phase_e ph,
		input logic [`DAC_CNT_W-1:0] c,
		input logic [`DAC_HALF_W-1:0] code
	);
		return (ph == PWM_RUN) && (c[`DAC_HALF_W-1:0] < code);
	endfunction

	// Stopped when both top bits are set, i.e. 255 after 0
	assign phase = (cnt[`DAC_CNT_W-1] & cnt[`DAC_CNT_W-2]) ? PWM_STOP : PWM_RUN;

	// Low half is sample bits 8..2
	assign code_l0 = dl2[`DAC_CODE_LSB+`DAC_HALF_W-1:`DAC_CODE_LSB];
	assign code_r0 = dr2[`DAC_CODE_LSB+`DAC_HALF_W-1:`DAC_CODE_LSB];

	// High half takes the sign inverted, over bits 14..9
	assign code_l1 = {~dl2[`DAC_SAMPLE_W-1], dl2[`DAC_SAMPLE_W-2:`DAC_SAMPLE_W-`DAC_HALF_W]};
	assign code_r1 = {~dr2[`DAC_SAMPLE_W-1], dr2[`DAC_SAMPLE_W-2:`DAC_SAMPLE_W-`DAC_HALF_W]};

	// Period is 128, then 127 down to 0, so a code c gives c+1 high ticks
	// Counter leaves reset at 0 and so runs for one tick
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			cnt <= '0;
		end else if (dac_tick) begin
			if (ts) begin
				cnt <= `DAC_CNT_W'(`DAC_CNT_START);
			end else if (phase == PWM_RUN) begin
				cnt <= cnt - 1'b1;
			end
		end
	end

	// Registered outputs, one tick behind the counter
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			ldac <= 2'b00;
			rdac <= 2'b00;
		end else if (dac_tick) begin
			ldac[0] <= pulse_on(phase, cnt, code_l0);
			ldac[1] <= pulse_on(phase, cnt, code_l1);
			rdac[0] <= pulse_on(phase, cnt, code_r0);
			rdac[1] <= pulse_on(phase, cnt, code_r1);
		end
	end

endmodule

`default_nettype wire

// File: src/dac_regs.sv
/* Double-buffered sample latches */

`timescale 1ns/10ps
`default_nettype none

`include "dac_defs.svh"

module dac_regs (
	input wire sys_clk,
	input wire resetl,
	input wire dac_tick,
	input wire tint,
	dac_bus_if.target bus,
	output logic [`DAC_SAMPLE_W-1:`DAC_CODE_LSB] dl2,
	output logic [`DAC_SAMPLE_W-1:`DAC_CODE_LSB] dr2
);
	import dac_bus_pkg::*;

	// First stage, written from the bus
	logic [`DAC_SAMPLE_W-1:`DAC_CODE_LSB] dl1;
	logic [`DAC_SAMPLE_W-1:`DAC_CODE_LSB] dr1;
	logic load;

	// A pending write completes on the next tick
	assign load = bus.wr & dac_tick;

	// Ack in the same cycle the latch takes the data
	assign bus.ack = load;

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			dl1 <= '0;
			dr1 <= '0;
			dl2 <= '0;
			dr2 <= '0;
		end else if (dac_tick) begin
			// Low sample bits are not kept
			if (load) begin
				if (bus.sel == SEL_LEFT) begin
					dl1 <= bus.data[`DAC_SAMPLE_W-1:`DAC_CODE_LSB];
				end else begin
					dr1 <= bus.data[`DAC_SAMPLE_W-1:`DAC_CODE_LSB];
				end
			end
			// Transfer strobe
			// A write on the same tick shows up one transfer later
			if (tint) begin
				dl2 <= dl1;
				dr2 <= dr1;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/bus_arbiter.sv
/* DSP and host write arbiter */

`timescale 1ns/10ps
`default_nettype none

`include "dac_defs.svh"

module bus_arbiter (
	input wire sys_clk,
	input wire resetl,
	input wire dsp_req,
	input wire dac_bus_pkg::dac_sel_e dsp_sel,
	input wire [`DAC_SAMPLE_W-1:0] dsp_data,
	output logic dsp_ack,
	input wire host_req,
	input wire dac_bus_pkg::dac_sel_e host_sel,
	input wire [`DAC_SAMPLE_W-1:0] host_data,
	output logic host_ack,
	dac_bus_if.master bus
);
	import dac_bus_pkg::*;

	arb_state_e state;
	arb_state_e state_nxt;

	// Fixed priority, DSP first
	// Grant held until ack, then back to idle for one cycle
	always_comb begin
		state_nxt = state;
		case (state)
			ARB_IDLE: begin
				if (dsp_req) begin
					state_nxt = ARB_DSP;
				end else if (host_req) begin
					state_nxt = ARB_HOST;
				end
			end
			ARB_DSP, ARB_HOST: begin
				if (bus.ack) begin
					state_nxt = ARB_IDLE;
				end
			end
			default: state_nxt = ARB_IDLE;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			state <= ARB_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// Granted writer onto the bus
	// Writers hold sel and data, so the mux output is stable too
	always_comb begin
		bus.wr = (state != ARB_IDLE);
		if (state == ARB_HOST) begin
			bus.sel = host_sel;
			bus.data = host_data;
		end else begin
			bus.sel = dsp_sel;
			bus.data = dsp_data;
		end
	end

	// Ack only back to the owner
	assign dsp_ack = bus.ack & (state == ARB_DSP);
	assign host_ack = bus.ack & (state == ARB_HOST);

endmodule

`default_nettype wire

// File: src/dac_bus_if.sv
/* Sample write bus */

`timescale 1ns/10ps
`default_nettype none

`include "dac_defs.svh"

interface dac_bus_if;
	import dac_bus_pkg::*;

	// Write pending, held with sel and data until ack
	logic wr;
	dac_sel_e sel;
	logic [`DAC_SAMPLE_W-1:0] data;
	// One-cycle pulse, wr seen on a tick
	logic ack;

	// Arbiter side
	modport master (output wr, output sel, output data, input ack);

	// Latch side
	modport target (input wr, input sel, input data, output ack);

endinterface

`default_nettype wire

// File: src/dac_pwm_pkg.sv
/* DAC PWM types */

`default_nettype none

package dac_pwm_pkg;

	// Counter phase
	// Stop is held once the two top counter bits are set
	typedef enum logic {
		PWM_RUN  = 1'b0,
		PWM_STOP = 1'b1
	} pwm_phase_e;

endpackage

`default_nettype wire

// File: src/dac_bus_pkg.sv
/* DAC write bus types */

`default_nettype none

package dac_bus_pkg;

	// Which first-stage latch a write targets
	typedef enum logic {
		SEL_LEFT  = 1'b0,
		SEL_RIGHT = 1'b1
	} dac_sel_e;

	// Arbiter grant state
	// ARB_IDLE means no writer owns the bus
	typedef enum logic [1:0] {
		ARB_IDLE = 2'd0,
		ARB_DSP  = 2'd1,
		ARB_HOST = 2'd2
	} arb_state_e;

endpackage

`default_nettype wire

// File: src/dac_defs.svh
/* Audio DAC widths and start values */

`ifndef DAC_DEFS_SVH
`define DAC_DEFS_SVH

// Width of the sample write bus
`define DAC_SAMPLE_W 16

// Lowest sample bit kept in the latches
// Bits below it are dropped on write
`define DAC_CODE_LSB 2

// Shared PWM down-counter
`define DAC_CNT_W 8

// Value loaded by ts at the start of a period
`define DAC_CNT_START 128

// Width of each low or high half pulse code
`define DAC_HALF_W 7

`endif
